// ==== Makefile ====
# Verilator build and run for the stream crosspoint testbench

VERILATOR ?= verilator
TOP       ?= tb_xp_crosspoint
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

SOURCES := $(wildcard rtl/*.sv bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_xp_crosspoint.sv ====
// Testbench for the registered stream crosspoint
// LFSR driven beats and route maps, reference model of maps and pipeline
// Concurrent assertions on output beats and frame counts, plus watchdog

`default_nettype none
`timescale 1ns/10ps

module tb_xp_crosspoint
    import xp_stream_pkg::*;
    import xp_route_pkg::*;
();

    localparam int S_COUNT = 4;
    localparam int M_COUNT = 4;
    localparam int PORT_W = $clog2(M_COUNT);
    localparam int CLK_HALF = 50;

    // Test length, also sets the watchdog limit
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 40;
    localparam int RUN_CYCLES = 24;
    localparam int N_MAPS = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES
        + (N_MAPS + 6) * (M_COUNT + 2 + 2 * RUN_CYCLES) + 200;

    typedef xp_route_t [M_COUNT-1:0] route_map_t;

    logic                        clk = 1'b0;
    logic                        rst;
    xp_beat_t      [S_COUNT-1:0] in_beats;
    xp_beat_t      [M_COUNT-1:0] out_beats;
    logic                        cfg_wr;
    logic          [PORT_W-1:0]  cfg_port;
    xp_route_t                   cfg_route;
    logic                        cfg_commit;
    logic                        cnt_clear;
    xp_frame_cnt_t [M_COUNT-1:0] frame_counts;

    // Reference model state
    xp_beat_t      [S_COUNT-1:0] hist1;
    xp_beat_t      [S_COUNT-1:0] hist2;
    route_map_t                  shadow_m;
    route_map_t                  active_m;
    // Map in force when the current outputs were switched
    route_map_t                  map_prev;
    xp_beat_t      [M_COUNT-1:0] exp_out;
    xp_frame_cnt_t [M_COUNT-1:0] cnt_m;

    // Proof that checks saw real traffic
    int beats_checked = 0;
    int frames_seen = 0;

    logic [31:0] lfsr_state = 32'hfb0c;

    always #CLK_HALF clk = ~clk;

    xp_crosspoint_top #(
        .S_COUNT(S_COUNT),
        .M_COUNT(M_COUNT)
    ) i_xp_crosspoint_top (
        .clk         (clk),
        .rst         (rst),
        .in_beats    (in_beats),
        .out_beats   (out_beats),
        .cfg_wr      (cfg_wr),
        .cfg_port    (cfg_port),
        .cfg_route   (cfg_route),
        .cfg_commit  (cfg_commit),
        .cnt_clear   (cnt_clear),
        .frame_counts(frame_counts)
    );

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out_bit ? 32'hd000_0001 : 32'h0);
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Mostly enabled entries, sources in range
    function automatic route_map_t random_map();
        route_map_t map;
        for (int m = 0; m < M_COUNT; m++) begin
            map[m].enable = lfsr_bit() | lfsr_bit();
            map[m].src = XP_SRC_W'(rand_bits(XP_SRC_W) % S_COUNT);
        end
        return map;
    endfunction

    // Valid about 3/4 of beats, last about 1/4
    task automatic drive_random_beats();
        for (int s = 0; s < S_COUNT; s++) begin
            in_beats[s].valid = lfsr_bit() | lfsr_bit();
            in_beats[s].data = rand_bits(XP_DATA_W);
            in_beats[s].keep = XP_KEEP_W'(rand_bits(XP_KEEP_W));
            in_beats[s].last = lfsr_bit() & lfsr_bit();
            in_beats[s].user = XP_USER_W'(rand_bits(XP_USER_W));
        end
    endtask

    // Strobes last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
        cfg_commit = 1'b0;
        cnt_clear = 1'b0;
        drive_random_beats();
    endtask

    // One shadow write per cycle, commit optionally with the final write
    task automatic load_map(input route_map_t map, input logic commit_with_last);
        for (int m = 0; m < M_COUNT; m++) begin
            next_cycle();
            cfg_wr = 1'b1;
            cfg_port = PORT_W'(m);
            cfg_route = map[m];
            if (m == M_COUNT - 1) begin
                cfg_commit = commit_with_last;
            end
        end
    endtask

    task automatic commit_map();
        next_cycle();
        cfg_commit = 1'b1;
    endtask

    task automatic report_mismatch(input string name, input int idx,
                                   input logic [63:0] got, input logic [63:0] expected);
        $display("Error: %s[%0d] got %h expected %h", name, idx, got, expected);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Model updates on the same edges as the DUT
    always @(posedge clk) begin : model_update
        route_map_t shadow_new;
        shadow_new = shadow_m;
        // A write in the commit cycle is part of the commit
        if (cfg_wr) begin
            shadow_new[cfg_port] = cfg_route;
        end
        hist2 <= hist1;
        hist1 <= in_beats;
        map_prev <= active_m;
        for (int m = 0; m < M_COUNT; m++) begin
            if (cnt_clear) begin
                cnt_m[m] <= '0;
            end else if (exp_out[m].valid && exp_out[m].last) begin
                cnt_m[m] <= cnt_m[m] + xp_frame_cnt_t'(1);
            end
            if (!rst && exp_out[m].valid) begin
                beats_checked++;
                if (exp_out[m].last) begin
                    frames_seen++;
                end
            end
        end
        if (rst) begin
            shadow_m <= '0;
            active_m <= '0;
            map_prev <= '0;
            cnt_m <= '0;
            for (int s = 0; s < S_COUNT; s++) begin
                hist1[s].valid <= 1'b0;
                hist2[s].valid <= 1'b0;
            end
        end else begin
            shadow_m <= shadow_new;
            if (cfg_commit) begin
                active_m <= shadow_new;
            end
        end
    end

    // Output = source beat two cycles back, switched by the map one cycle back
    always_comb begin
        for (int m = 0; m < M_COUNT; m++) begin
            exp_out[m] = hist2[int'(map_prev[m].src)];
            exp_out[m].valid = map_prev[m].enable && hist2[int'(map_prev[m].src)].valid;
        end
    end

    for (genvar m = 0; m < M_COUNT; m++) begin : g_check
        // Valid holds for disabled entries too
        a_out_valid: assert property (
            @(posedge clk) disable iff (rst)
            out_beats[m].valid == exp_out[m].valid
        ) else report_mismatch("out_beats.valid", m, 64'($sampled(out_beats[m].valid)),
                               64'($sampled(exp_out[m].valid)));

        // Every field when the route is enabled
        a_out_beat: assert property (
            @(posedge clk) disable iff (rst)
            map_prev[m].enable |-> (out_beats[m] == exp_out[m])
        ) else report_mismatch("out_beats", m, 64'($sampled(out_beats[m])),
                               64'($sampled(exp_out[m])));

        a_frame_count: assert property (
            @(posedge clk) disable iff (rst)
            frame_counts[m] == cnt_m[m]
        ) else report_mismatch("frame_counts", m, 64'($sampled(frame_counts[m])),
                               64'($sampled(cnt_m[m])));
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the test sequence completed");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin : stimulus
        route_map_t map;
        logic       same_cycle;
        rst = 1'b1;
        cfg_wr = 1'b0;
        cfg_port = '0;
        cfg_route = '0;
        cfg_commit = 1'b0;
        cnt_clear = 1'b0;
        in_beats = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;

        // All entries disabled after reset
        repeat (IDLE_CYCLES) next_cycle();

        // Identity map, commit together with the last write
        for (int m = 0; m < M_COUNT; m++) begin
            map[m].enable = 1'b1;
            map[m].src = XP_SRC_W'(m % S_COUNT);
        end
        load_map(map, 1'b1);
        repeat (RUN_CYCLES) next_cycle();

        // Broadcast of one source to every output
        for (int m = 0; m < M_COUNT; m++) begin
            map[m].enable = 1'b1;
            map[m].src = XP_SRC_W'(S_COUNT / 2);
        end
        load_map(map, 1'b0);
        commit_map();
        repeat (RUN_CYCLES) next_cycle();

        // Random maps, commit in the write cycle or just after
        for (int i = 0; i < N_MAPS; i++) begin
            map = random_map();
            same_cycle = lfsr_bit();
            load_map(map, same_cycle);
            if (!same_cycle) begin
                commit_map();
            end
            repeat (RUN_CYCLES) next_cycle();
        end

        // Shadow writes stay hidden until the commit
        map = random_map();
        load_map(map, 1'b0);
        repeat (RUN_CYCLES) next_cycle();
        commit_map();
        repeat (RUN_CYCLES) next_cycle();

        // Output 1 disabled, the others keep flowing
        for (int m = 0; m < M_COUNT; m++) begin
            map[m].enable = (m != 1);
            map[m].src = XP_SRC_W'((m + 1) % S_COUNT);
        end
        load_map(map, 1'b1);
        repeat (RUN_CYCLES) next_cycle();

        // Clear the frame counts mid traffic
        next_cycle();
        cnt_clear = 1'b1;
        repeat (RUN_CYCLES) next_cycle();
        repeat (4) next_cycle();

        if (beats_checked == 0 || frames_seen == 0) begin
            $display("Stimulus produced no valid output beats or no completed frames");
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule : tb_xp_crosspoint

`default_nettype wire

// ==== rtl/xp_crosspoint_top.sv ====
// Top level of the registered stream crosspoint
// Input stage, route table, switch stage and frame monitor
// Port counts set here and passed down to every block

`default_nettype none
`timescale 1ns/10ps

module xp_crosspoint_top
    import xp_stream_pkg::*;
    import xp_route_pkg::*;
#(
    parameter int S_COUNT = 4,
    parameter int M_COUNT = 4,
    localparam int PORT_W = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // Streams in and out, two cycles of latency
    input  wire xp_beat_t      [S_COUNT-1:0] in_beats,
    output      xp_beat_t      [M_COUNT-1:0] out_beats,

    // Route map programming
    input  wire logic                        cfg_wr,
    input  wire logic          [PORT_W-1:0]  cfg_port,
    input  wire xp_route_t                   cfg_route,
    input  wire logic                        cfg_commit,

    // Frame statistics
    input  wire logic                        cnt_clear,
    output      xp_frame_cnt_t [M_COUNT-1:0] frame_counts
);

    // Inputs after the first register stage
    xp_beat_t  [S_COUNT-1:0] staged_beats;
    // Map used to steer the second stage
    xp_route_t [M_COUNT-1:0] active_map;

    xp_input_stage #(
        .S_COUNT(S_COUNT)
    ) i_xp_input_stage (
        .clk         (clk),
        .rst         (rst),
        .in_beats    (in_beats),
        .staged_beats(staged_beats)
    );

    // Commit lands on the edge before the matching beat is switched
    xp_route_table #(
        .S_COUNT(S_COUNT),
        .M_COUNT(M_COUNT)
    ) i_xp_route_table (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_port  (cfg_port),
        .cfg_route (cfg_route),
        .cfg_commit(cfg_commit),
        .active_map(active_map)
    );

    xp_switch_stage #(
        .S_COUNT(S_COUNT),
        .M_COUNT(M_COUNT)
    ) i_xp_switch_stage (
        .clk         (clk),
        .rst         (rst),
        .staged_beats(staged_beats),
        .active_map  (active_map),
        .out_beats   (out_beats)
    );

    // Watches the registered outputs
    xp_frame_monitor #(
        .M_COUNT(M_COUNT)
    ) i_xp_frame_monitor (
        .clk         (clk),
        .rst         (rst),
        .cnt_clear   (cnt_clear),
        .out_beats   (out_beats),
        .frame_counts(frame_counts)
    );

endmodule : xp_crosspoint_top

`default_nettype wire

// ==== rtl/xp_frame_monitor.sv ====
// Frame monitor for the crosspoint outputs
// One wrapping counter per output, bumped on valid last beats
// Clear pulse zeroes every counter

`default_nettype none
`timescale 1ns/10ps

module xp_frame_monitor
    import xp_stream_pkg::*;
    import xp_route_pkg::*;
#(
    parameter int M_COUNT = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Zero all counts, wins over a same cycle increment
    input  wire logic                       cnt_clear,

    // Output beats as driven by the switch stage
    input  wire xp_beat_t  [M_COUNT-1:0]    out_beats,

    // Completed frames seen on each output
    output      xp_frame_cnt_t [M_COUNT-1:0] frame_counts
);

    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            frame_counts <= '0;
        end else begin
            for (int m = 0; m < M_COUNT; m++) begin
                // A frame ends on a valid beat with last set
                if (out_beats[m].valid && out_beats[m].last) begin
                    // Natural wrap at the counter width
                    frame_counts[m] <= frame_counts[m] + 1'b1;
                end
            end
        end
    end

endmodule : xp_frame_monitor

`default_nettype wire

// ==== rtl/xp_input_stage.sv ====
// First pipeline stage of the crosspoint
// Registers every input beat once before the switch

`default_nettype none
`timescale 1ns/10ps

module xp_input_stage
    import xp_stream_pkg::*;
#(
    parameter int S_COUNT = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,

    // Raw beats from the input streams
    input  wire xp_beat_t [S_COUNT-1:0] in_beats,

    // Registered copy for the switch stage
    output      xp_beat_t [S_COUNT-1:0] staged_beats
);

    // Payload goes straight through the flops every cycle
    // Only valid needs a known state after reset
    always_ff @(posedge clk) begin
        for (int s = 0; s < S_COUNT; s++) begin
            staged_beats[s] <= in_beats[s];
        end

        if (rst) begin
            for (int s = 0; s < S_COUNT; s++) begin
                staged_beats[s].valid <= 1'b0;
            end
        end
    end

endmodule : xp_input_stage

`default_nettype wire

// ==== rtl/xp_route_pkg.sv ====
// Route map and monitor definitions for the crosspoint
// Source index width, route entry struct and frame count type

`default_nettype none

package xp_route_pkg;

    // Width of a source index
    // Caps the input count at 16
    localparam int XP_SRC_W = 4;

    // Frame counter width
    localparam int XP_FRAME_CNT_W = 16;

    // One entry of the route map, one entry per output
    typedef struct packed {
        // Output drives valid low when clear
        logic                enable;
        // Input that feeds this output
        logic [XP_SRC_W-1:0] src;
    } xp_route_t;

    // Completed frames per output, wraps at the top
    typedef logic [XP_FRAME_CNT_W-1:0] xp_frame_cnt_t;

endpackage : xp_route_pkg

`default_nettype wire

// ==== rtl/xp_route_table.sv ====
// Route map storage for the crosspoint
// Shadow table written one entry at a time
// Active table loaded from the shadow on a commit pulse
// Write range checks on the configuration port

`default_nettype none
`timescale 1ns/10ps

module xp_route_table
    import xp_route_pkg::*;
#(
    parameter int S_COUNT = 4,
    parameter int M_COUNT = 4,
    localparam int PORT_W = (M_COUNT > 1) ? $clog2(M_COUNT) : 1
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Single entry write into the shadow table
    input  wire logic                    cfg_wr,
    input  wire logic [PORT_W-1:0]       cfg_port,
    input  wire xp_route_t               cfg_route,

    // Copies the whole shadow into the active map
    input  wire logic                    cfg_commit,

    // Map in use by the switch stage
    output      xp_route_t [M_COUNT-1:0] active_map
);

    // Entries staged by software, not yet visible to the switch
    xp_route_t [M_COUNT-1:0] shadow_map;
    // Shadow contents including this cycle's write
    xp_route_t [M_COUNT-1:0] shadow_next;

    // Merge the pending write so a commit in the same cycle sees it
    always_comb begin
        shadow_next = shadow_map;
        if (cfg_wr) begin
            shadow_next[cfg_port] = cfg_route;
        end
    end

    // Whole map swaps on one edge
    // All outputs change source together
    always_ff @(posedge clk) begin
        if (rst) begin
            // Every entry disabled
            shadow_map <= '0;
            active_map <= '0;
        end else begin
            shadow_map <= shadow_next;
            if (cfg_commit) begin
                active_map <= shadow_next;
            end
        end
    end

    // Writes must name a real output
    a_cfg_port_range: assert property (
        @(posedge clk) disable iff (rst)
        cfg_wr |-> (int'(cfg_port) < M_COUNT)
    ) else $error("route table write to output %0d out of range", cfg_port);

    // Enabled entries must name a real input
    a_cfg_src_range: assert property (
        @(posedge clk) disable iff (rst)
        (cfg_wr && cfg_route.enable) |-> (int'(cfg_route.src) < S_COUNT)
    ) else $error("route table source %0d out of range", cfg_route.src);

endmodule : xp_route_table

`default_nettype wire

// ==== rtl/xp_stream_pkg.sv ====
// Stream beat definitions shared by the crosspoint datapath
// Field widths for data, keep and user
// Packed beat struct carried on every input and output port

`default_nettype none

package xp_stream_pkg;

    // Beat payload widths
    localparam int XP_DATA_W = 32;
    // One keep bit per data byte
    localparam int XP_KEEP_W = XP_DATA_W / 8;
    localparam int XP_USER_W = 1;

    // One stream beat of 39 bits
    // Valid is a plain level with no ready behind it
    typedef struct packed {
        logic                 valid;
        logic [XP_DATA_W-1:0] data;
        logic [XP_KEEP_W-1:0] keep;
        // End of frame marker
        logic                 last;
        logic [XP_USER_W-1:0] user;
    } xp_beat_t;

endpackage : xp_stream_pkg

`default_nettype wire

// ==== rtl/xp_switch_stage.sv ====
// Second pipeline stage of the crosspoint
// Picks one staged input beat per output through the active map
// Registers the result as the output beat
// Checks each output valid against the map and source a cycle back

`default_nettype none
`timescale 1ns/10ps

module xp_switch_stage
    import xp_stream_pkg::*;
    import xp_route_pkg::*;
#(
    parameter int S_COUNT = 4,
    parameter int M_COUNT = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Registered input beats from the first stage
    input  wire xp_beat_t  [S_COUNT-1:0] staged_beats,

    // Current route map, one entry per output
    input  wire xp_route_t [M_COUNT-1:0] active_map,

    // Registered output beats
    output      xp_beat_t  [M_COUNT-1:0] out_beats
);

    for (genvar m = 0; m < M_COUNT; m++) begin : g_out
        // Entry for this output
        xp_route_t route;
        // Staged beat of the mapped source
        xp_beat_t  sel_beat;
        // Entry enabled and pointing at a real input
        logic      route_ok;

        assign route    = active_map[m];
        assign route_ok = route.enable && (int'(route.src) < S_COUNT);
        assign sel_beat = staged_beats[route.src];

        // Payload follows the selected source without reset
        always_ff @(posedge clk) begin
            out_beats[m]       <= sel_beat;
            // Disabled output drops valid but keeps moving data
            out_beats[m].valid <= route_ok && sel_beat.valid;

            if (rst) begin
                out_beats[m].valid <= 1'b0;
            end
        end

        // Output valid needs an enabled entry and a valid source beat
        // both seen on the edge that loaded this output
        a_valid_source: assert property (
            @(posedge clk) disable iff (rst)
            out_beats[m].valid |->
                ($past(active_map[m].enable) &&
                 $past(staged_beats[active_map[m].src].valid))
        ) else $error("output %0d valid without enabled route and valid source", m);
    end

endmodule : xp_switch_stage

`default_nettype wire

// ==== verilog.f ====
rtl/xp_stream_pkg.sv
rtl/xp_route_pkg.sv
rtl/xp_input_stage.sv
rtl/xp_route_table.sv
rtl/xp_switch_stage.sv
rtl/xp_frame_monitor.sv
rtl/xp_crosspoint_top.sv
bench/tb_xp_crosspoint.sv
